// ==== Bender.yml ====
package:
  name: rv_exec

sources:
  - rv_exec_pkg.sv
  - op_if.sv
  - reg_file.sv
  - issue_unit.sv
  - op_queue.sv
  - exec_unit.sv
  - rv_exec_top.sv
  - target: test
    files:
      - rv_exec_chk.sv
      - tb_rv_exec.sv

// ==== exec_unit.sv ====
module exec_unit (
  input  logic                  clk,
  input  logic                  rst,
  op_if.pop                     head,
  output logic                  wb_valid,
  output rv_exec_pkg::reg_idx_t wb_rd,
  output rv_exec_pkg::xlen_t    wb_data,
  input  logic                  wb_ready
);

  rv_exec_pkg::xlen_t result;
  logic               pop_fire;

  // Take a new op when the output slot is free or draining.
  assign head.ready = !wb_valid || wb_ready;
  assign pop_fire   = head.valid && head.ready;

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------
  always_comb begin
    case (head.op)
      rv_exec_pkg::ALU_ADD,
      rv_exec_pkg::ALU_ADDI: result = head.a + head.b;
      rv_exec_pkg::ALU_SUB:  result = head.a - head.b;
      rv_exec_pkg::ALU_AND,
      rv_exec_pkg::ALU_ANDI: result = head.a & head.b;
      rv_exec_pkg::ALU_OR,
      rv_exec_pkg::ALU_ORI:  result = head.a | head.b;
      rv_exec_pkg::ALU_XOR,
      rv_exec_pkg::ALU_XORI: result = head.a ^ head.b;
      rv_exec_pkg::ALU_SLL:  result = head.a << head.b[5:0];
      rv_exec_pkg::ALU_SRL:  result = head.a >> head.b[5:0];
      rv_exec_pkg::ALU_SLT:  result = {63'd0, $signed(head.a) < $signed(head.b)};
      default:               result = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Writeback register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (pop_fire) begin
      wb_valid <= 1'b1;
    end else if (wb_ready) begin
      wb_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_fire) begin
      wb_rd   <= head.rd;
      wb_data <= result;
    end
  end

endmodule

// ==== issue_unit.sv ====
module issue_unit (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  instr_valid,
  input  rv_exec_pkg::instr_t   instr,
  output logic                  instr_ready,

  output rv_exec_pkg::reg_idx_t rs1_addr,
  output rv_exec_pkg::reg_idx_t rs2_addr,
  input  rv_exec_pkg::xlen_t    rs1_data,
  input  rv_exec_pkg::xlen_t    rs2_data,

  input  logic                  wb_done,
  input  rv_exec_pkg::reg_idx_t wb_rd,

  op_if.push                    issue
);

  rv_exec_pkg::opcode_t  opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  rv_exec_pkg::reg_idx_t rd;
  rv_exec_pkg::xlen_t    imm;
  rv_exec_pkg::alu_op_e  op;
  logic                  legal;
  logic                  is_imm;
  logic                  hazard;
  logic                  accept;
  logic [31:0]           pending;  // One bit per register.

  assign opcode   = instr[6:0];
  assign rd       = instr[11:7];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign funct7   = instr[31:25];
  assign imm      = {{(rv_exec_pkg::XLEN - 12){instr[31]}}, instr[31:20]};

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  always_comb begin
    op     = rv_exec_pkg::ALU_ADD;
    legal  = 1'b0;
    is_imm = 1'b0;
    if (opcode == rv_exec_pkg::OPC_OP) begin
      legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 && funct3 == 3'b000);
      case (funct3)
        3'b000:  op = funct7[5] ? rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
        3'b001:  op = rv_exec_pkg::ALU_SLL;
        3'b010:  op = rv_exec_pkg::ALU_SLT;
        3'b100:  op = rv_exec_pkg::ALU_XOR;
        3'b101:  op = rv_exec_pkg::ALU_SRL;
        3'b110:  op = rv_exec_pkg::ALU_OR;
        3'b111:  op = rv_exec_pkg::ALU_AND;
        default: legal = 1'b0;  // SLTU not supported.
      endcase
    end else if (opcode == rv_exec_pkg::OPC_OP_IMM) begin
      is_imm = 1'b1;
      legal  = 1'b1;
      case (funct3)
        3'b000:  op = rv_exec_pkg::ALU_ADDI;
        3'b100:  op = rv_exec_pkg::ALU_XORI;
        3'b110:  op = rv_exec_pkg::ALU_ORI;
        3'b111:  op = rv_exec_pkg::ALU_ANDI;
        default: legal = 1'b0;  // SLTI and shifts not supported.
      endcase
    end
  end

  // RAW on the sources, WAW on the destination. rs2 is immediate bits for I-type.
  assign hazard = legal && (pending[rs1_addr] || (!is_imm && pending[rs2_addr]) || pending[rd]);

  assign instr_ready = !rst && issue.ready && !hazard;
  assign accept      = instr_valid && instr_ready;

  assign issue.valid = instr_valid && legal && !hazard && !rst;
  assign issue.op    = op;
  assign issue.rd    = rd;
  assign issue.a     = rs1_data;
  assign issue.b     = is_imm ? imm : rs2_data;

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb_done) begin
        pending[wb_rd] <= 1'b0;
      end
      if (accept && legal && rd != '0) begin
        pending[rd] <= 1'b1;  // Later assignment, so set wins.
      end
    end
  end

endmodule

// ==== op_if.sv ====
interface op_if;

  logic                  valid;
  logic                  ready;
  rv_exec_pkg::alu_op_e  op;
  rv_exec_pkg::reg_idx_t rd;
  rv_exec_pkg::xlen_t    a;
  rv_exec_pkg::xlen_t    b;  // Holds the immediate for I-type ops.

  modport push (
    output valid,
    output op,
    output rd,
    output a,
    output b,
    input  ready
  );

  modport pop (
    input  valid,
    input  op,
    input  rd,
    input  a,
    input  b,
    output ready
  );

endinterface

// ==== op_queue.sv ====
module op_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  op_if.pop    push,
  op_if.push   pop
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  rv_exec_pkg::alu_op_e  op_mem [DEPTH];
  rv_exec_pkg::reg_idx_t rd_mem [DEPTH];
  rv_exec_pkg::xlen_t    a_mem  [DEPTH];
  rv_exec_pkg::xlen_t    b_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             empty;
  logic             push_fire;
  logic             pop_fire;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // A full queue still takes a push when the head leaves on the same edge.
  assign push.ready = !full || pop.ready;
  assign pop.valid  = !empty;
  assign push_fire  = push.valid && push.ready;
  assign pop_fire   = pop.valid && pop.ready;

  assign pop.op = op_mem[rd_ptr];
  assign pop.rd = rd_mem[rd_ptr];
  assign pop.a  = a_mem[rd_ptr];
  assign pop.b  = b_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_fire) begin
      op_mem[wr_ptr] <= push.op;
      rd_mem[wr_ptr] <= push.rd;
      a_mem[wr_ptr]  <= push.a;
      b_mem[wr_ptr]  <= push.b;
    end
  end

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push_fire && !pop_fire) begin
        count <= count + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== reg_file.sv ====
module reg_file (
  input  logic                  clk,
  input  logic                  rst,

  input  rv_exec_pkg::reg_idx_t rs1_addr,
  input  rv_exec_pkg::reg_idx_t rs2_addr,
  output rv_exec_pkg::xlen_t    rs1_data,
  output rv_exec_pkg::xlen_t    rs2_data,

  input  logic                  we,
  input  rv_exec_pkg::reg_idx_t waddr,
  input  rv_exec_pkg::xlen_t    wdata
);

  rv_exec_pkg::xlen_t regs [rv_exec_pkg::NUM_REGS];

  logic wr_en;

  // x0 is hardwired to zero.
  assign wr_en = we && (waddr != '0);

  // ----------------------------------------------------------------------
  // Read ports
  // ----------------------------------------------------------------------
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_exec_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// ==== rv_exec.f ====
rv_exec_pkg.sv
op_if.sv
reg_file.sv
issue_unit.sv
op_queue.sv
exec_unit.sv
rv_exec_top.sv
rv_exec_chk.sv
tb_rv_exec.sv

// ==== rv_exec_chk.sv ====
module rv_exec_chk #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input logic                                 clk,
  input logic                                 rst,
  input logic                                 instr_ready,
  input logic                                 wb_valid,
  input logic                                 wb_ready,
  input rv_exec_pkg::reg_idx_t                wb_rd,
  input rv_exec_pkg::xlen_t                   wb_data,
  input logic [$clog2(QUEUE_DEPTH + 1)-1:0]   queue_count
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Read by the testbench at the end of the run.

  a_ready_in_reset : assert property (@(posedge clk) rst |-> !instr_ready)
    else begin
      fail_count++;
      $error("instr_ready is high while rst is asserted");
    end

  // Reset clears the writeback register on the edge it is sampled.
  a_wb_in_reset : assert property (@(posedge clk) rst |=> !wb_valid)
    else begin
      fail_count++;
      $error("wb_valid is high after a reset edge");
    end

  a_wb_stable : assert property (@(posedge clk) disable iff (rst)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb_rd) && $stable(wb_data))
    else begin
      fail_count++;
      $error("Writeback changed while wb_ready was low");
    end

  a_queue_bound : assert property (@(posedge clk) disable iff (rst)
      queue_count <= QUEUE_DEPTH)
    else begin
      fail_count++;
      $error("Queue occupancy exceeds its depth");
    end

endmodule

bind rv_exec_top rv_exec_chk #(
  .QUEUE_DEPTH (QUEUE_DEPTH)
) u_chk (
  .clk         (clk),
  .rst         (rst),
  .instr_ready (instr_ready),
  .wb_valid    (wb_valid),
  .wb_ready    (wb_ready),
  .wb_rd       (wb_rd),
  .wb_data     (wb_data),
  .queue_count (u_queue.count)
);

// ==== rv_exec_pkg.sv ====
package rv_exec_pkg;

  // ----------------------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------------------
  localparam int unsigned XLEN = 64;
  localparam int unsigned NUM_REGS = 32;

  // Default depth of the decoded-operation queue.
  parameter int unsigned QUEUE_DEPTH = 4;

  typedef logic [XLEN-1:0] xlen_t;   // Register data word.
  typedef logic [4:0]      reg_idx_t; // Register index.
  typedef logic [31:0]     instr_t;   // Raw instruction word.
  typedef logic [6:0]      opcode_t;  // Major opcode field.

  // ----------------------------------------------------------------------
  // Operations
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLT  = 4'd7,
    ALU_ADDI = 4'd8,
    ALU_ANDI = 4'd9,
    ALU_ORI  = 4'd10,
    ALU_XORI = 4'd11
  } alu_op_e;

  // RV64I major opcodes.
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;

endpackage

// ==== rv_exec_top.sv ====
module rv_exec_top #(
  parameter int unsigned QUEUE_DEPTH = rv_exec_pkg::QUEUE_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  instr_valid,
  input  rv_exec_pkg::instr_t   instr,
  output logic                  instr_ready,

  output logic                  wb_valid,
  output rv_exec_pkg::reg_idx_t wb_rd,
  output rv_exec_pkg::xlen_t    wb_data,
  input  logic                  wb_ready
);

  rv_exec_pkg::reg_idx_t rs1_addr;
  rv_exec_pkg::reg_idx_t rs2_addr;
  rv_exec_pkg::xlen_t    rs1_data;
  rv_exec_pkg::xlen_t    rs2_data;
  logic                  wb_fire;

  op_if issue_q ();
  op_if q_exec ();

  // Result retires on the writeback handshake.
  assign wb_fire = wb_valid && wb_ready;

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (wb_fire),
    .waddr    (wb_rd),
    .wdata    (wb_data)
  );

  issue_unit u_issue (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wb_done     (wb_fire),
    .wb_rd       (wb_rd),
    .issue       (issue_q.push)
  );

  op_queue #(
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk  (clk),
    .rst  (rst),
    .push (issue_q.pop),
    .pop  (q_exec.push)
  );

  exec_unit u_exec (
    .clk      (clk),
    .rst      (rst),
    .head     (q_exec.pop),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .wb_ready (wb_ready)
  );

endmodule

// ==== tb_rv_exec.sv ====
module tb_rv_exec;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int CLK_PERIOD = 4;
  localparam int TOTAL_INSTR = 8 + 231 + 60 + 40 + 150 + 100;

  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_SLT,
    K_ADDI, K_ANDI, K_ORI, K_XORI, K_ILLEGAL
  } kind_e;

  logic                  clk;
  logic                  rst;
  logic                  instr_valid;
  rv_exec_pkg::instr_t   instr;
  logic                  instr_ready;
  logic                  wb_valid;
  rv_exec_pkg::reg_idx_t wb_rd;
  rv_exec_pkg::xlen_t    wb_data;
  logic                  wb_ready;

  logic [63:0] model_regs [32];
  logic [68:0] exp_q [$];  // {rd, data} in program order.
  int          errors = 0;
  int          checks = 0;
  int          err_mark = 0;
  int          test_num = 1;
  int          sent_count = 0;
  int          legal_sent = 0;
  int          wb_count = 0;
  int          ready_mode = 0;  // 0 always ready, 1 mostly ready, 2 long stalls.
  int          hold_cycles = 0;
  bit          full_stall_seen = 1'b0;

  rv_exec_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_rv_exec (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_ready    (wb_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Encoding and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] encode(input kind_e kind, input int rd, input int rs1,
                                         input int rs2, input logic [11:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opc;
    f7 = (kind == K_SUB) ? 7'b0100000 : 7'b0000000;
    case (kind)
      K_SLL:         f3 = 3'd1;
      K_SLT:         f3 = 3'd2;
      K_XOR, K_XORI: f3 = 3'd4;
      K_SRL:         f3 = 3'd5;
      K_OR, K_ORI:   f3 = 3'd6;
      K_AND, K_ANDI: f3 = 3'd7;
      default:       f3 = 3'd0;
    endcase
    if (kind < K_ADDI) begin
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    end else if (kind != K_ILLEGAL) begin
      return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    end
    // Unsupported funct3 under the two supported opcodes.
    case ($urandom_range(3))
      0: return {7'b0000000, 5'(rs2), 5'(rs1), 3'd3, 5'(rd), 7'b0110011};  // SLTU.
      1: return {imm, 5'(rs1), 3'd2, 5'(rd), 7'b0010011};                  // SLTI.
      default: ;
    endcase
    opc = 7'($urandom);
    while (opc == 7'b0110011 || opc == 7'b0010011) opc = 7'($urandom);
    return {25'($urandom), opc};
  endfunction

  function automatic logic [63:0] alu_model(input kind_e kind, input logic [63:0] a,
                                            input logic [63:0] b);
    case (kind)
      K_ADD, K_ADDI: return a + b;
      K_SUB:         return a - b;
      K_AND, K_ANDI: return a & b;
      K_OR, K_ORI:   return a | b;
      K_XOR, K_XORI: return a ^ b;
      K_SLL:         return a << b[5:0];
      K_SRL:         return a >> b[5:0];
      K_SLT:         return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      default:       return 64'd0;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Driver
  // ----------------------------------------------------------------------
  task automatic send(input kind_e kind, input int rd, input int rs1, input int rs2,
                      input logic [11:0] imm);
    logic [63:0] b;
    logic [63:0] res;
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = encode(kind, rd, rs1, rs2, imm);
    #1;
    while (!instr_ready) begin
      @(negedge clk);
      #1;
    end
    sent_count++;
    if (kind != K_ILLEGAL) begin  // Transfer happens on the coming rising edge.
      b   = (kind >= K_ADDI) ? {{52{imm[11]}}, imm} : model_regs[rs2];
      res = alu_model(kind, model_regs[rs1], b);
      exp_q.push_back({5'(rd), res});
      legal_sent++;
      if (rd != 0) begin
        model_regs[rd] = res;
      end
    end
  endtask

  task automatic send_random(input kind_e first, input kind_e last, input int reg_lo,
                             input int reg_hi, input int illegal_in);
    kind_e kind;
    kind = kind_e'($urandom_range(last, first));
    if ($urandom_range(illegal_in - 1) == 0) begin
      kind = K_ILLEGAL;
    end
    send(kind, $urandom_range(reg_hi, reg_lo), $urandom_range(reg_hi, reg_lo),
         $urandom_range(reg_hi, reg_lo), 12'($urandom));
  endtask

  task automatic begin_test(input int mode, input int hold);
    @(posedge clk);
    ready_mode  = mode;
    hold_cycles = hold;
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    instr_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (5) @(negedge clk);  // Catch late duplicate writebacks.
    check_value("writeback count", 64'(wb_count), 64'(legal_sent));
    $display("Test %0d %s: %0d sent, %0d retired, %0d errors", test_num, name,
             sent_count, wb_count, errors - err_mark);
    test_num++;
    sent_count = 0;
    legal_sent = 0;
    wb_count   = 0;
    err_mark   = errors;
  endtask

  // ----------------------------------------------------------------------
  // Writeback side and monitor
  // ----------------------------------------------------------------------
  initial begin : writeback_side
    logic [68:0] expected;
    wb_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (hold_cycles > 0) begin
        wb_ready = 1'b0;
        hold_cycles--;
      end else if (ready_mode == 0) begin
        wb_ready = 1'b1;
      end else if (ready_mode == 1) begin
        wb_ready = ($urandom_range(3) != 0);
      end else begin
        if ($urandom_range(11) == 0) begin
          hold_cycles = $urandom_range(40, 16);
        end
        wb_ready = $urandom_range(1);
      end
      #1;
      if (instr_valid && !instr_ready && u_rv_exec.u_queue.full) begin
        full_stall_seen = 1'b1;
      end
      if (wb_valid && wb_ready) begin
        wb_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected writeback to x%0d at %0t with no instruction outstanding",
                   wb_rd, $time);
        end else begin
          expected = exp_q.pop_front();
          check_value("wb_rd", 64'(wb_rd), 64'(expected[68:64]));
          check_value("wb_data", wb_data, expected[63:0]);
        end
      end
    end
  end

  initial begin : watchdog
    #(TOTAL_INSTR * 40 * CLK_PERIOD);
    $display("Run timed out at %0t with %0d results still pending", $time, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : main
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(32'h8fa5));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) begin
      @(negedge clk);
      check_value("instr_ready in reset", 64'(instr_ready), 64'd0);
      check_value("wb_valid in reset", 64'(wb_valid), 64'd0);
    end
    rst = 1'b0;
    #1;
    check_value("instr_ready after reset", 64'(instr_ready), 64'd1);

    begin_test(0, 0);
    repeat (8) begin
      send($urandom_range(1) ? K_OR : K_ADD, $urandom_range(31, 1),
           $urandom_range(31, 1), $urandom_range(31, 1), 12'd0);
    end
    end_test("reset_state");

    begin_test(1, 0);
    for (int r = 1; r < 32; r++) begin
      send(K_ADDI, r, 0, 0, 12'($urandom));  // Seed every register.
    end
    repeat (200) send_random(K_ADD, K_SLT, 1, 31, 20);
    end_test("reg_reg_ops");

    begin_test(1, 0);
    repeat (60) send_random(K_ADDI, K_XORI, 0, 31, 20);
    end_test("imm_ops");

    begin_test(1, 0);
    repeat (40) send_random(K_ADD, K_XORI, 0, 3, 20);
    end_test("x0_reg");

    begin_test(2, 40);
    repeat (10) begin
      send(kind_e'($urandom_range(11)), 0, $urandom_range(4), $urandom_range(4),
           12'($urandom));  // x0 is never pending, so these fill the queue.
    end
    repeat (140) send_random(K_ADD, K_XORI, 1, 4, 20);
    end_test("hazard_backpressure");
    if (!full_stall_seen) begin
      errors++;
      $display("instr_ready never fell while the queue was full");
    end

    begin_test(1, 0);
    repeat (100) send_random(K_ADD, K_XORI, 1, 31, 4);
    end_test("illegal_opcodes");

    errors = errors + u_rv_exec.u_chk.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d errors", test_num - 1, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
